//--- rtl/core_pkg.sv
package core_pkg;

  typedef logic [31:0] word_t;
  typedef logic [4:0]  reg_idx_t;
  typedef logic [6:0]  opcode_t;

  typedef enum logic [2:0] {FETCH, DECODE, EX, MEM, WB} ctrl_state_t;

  // subtraction is ALU_ADD with the B operand negated
  typedef enum logic [2:0] {
    ALU_ADD, ALU_AND, ALU_OR, ALU_XOR, ALU_SLT, ALU_SLL, ALU_SRL
  } alu_op_t;

  // WB_PC4 writes the PC plus 4
  typedef enum logic [1:0] {WB_ALU, WB_MEM, WB_PC4} wb_src_t;

  typedef enum logic [1:0] {NPC_INC, NPC_JUMP, NPC_BR_EQ, NPC_BR_NE} next_pc_t;

  // A_ZERO feeds LUI
  typedef enum logic [1:0] {A_REG, A_PC, A_ZERO} a_src_t;

  typedef enum logic {B_REG, B_IMM} b_src_t;

  // major opcodes
  localparam opcode_t OP_LUI    = 7'b0110111;
  localparam opcode_t OP_IMM    = 7'b0010011;
  localparam opcode_t OP_REG    = 7'b0110011;
  localparam opcode_t OP_LOAD   = 7'b0000011;
  localparam opcode_t OP_STORE  = 7'b0100011;
  localparam opcode_t OP_BRANCH = 7'b1100011;
  localparam opcode_t OP_JAL    = 7'b1101111;

endpackage

//--- rtl/decode_if.sv
`timescale 1ns/1ps

interface decode_if import core_pkg::*; ();
  reg_idx_t rs1;
  reg_idx_t rs2;
  reg_idx_t rd;
  word_t    imm;
  alu_op_t  alu_op;
  logic     negate_b;
  a_src_t   a_src;
  b_src_t   b_src;
  logic     reg_w;
  logic     mem_r;
  logic     mem_w;
  wb_src_t  wb_src;
  next_pc_t next_pc;
  logic     nop;

  modport source (
    output rs1, rs2, rd, imm, alu_op, negate_b, a_src, b_src,
    output reg_w, mem_r, mem_w, wb_src, next_pc, nop
  );

  modport sink (
    input rs1, rs2, rd, imm, alu_op, negate_b, a_src, b_src,
    input reg_w, mem_r, mem_w, wb_src, next_pc, nop
  );

  modport control (input nop, mem_r, mem_w, reg_w);
endinterface

//--- rtl/decoder.sv
`timescale 1ns/1ps

module decoder import core_pkg::*; (
  input  word_t    instr_i,
  decode_if.source dec
);

  opcode_t    opcode;
  logic [2:0] funct3;
  logic [6:0] funct7;
  word_t      imm_i;
  word_t      imm_s;
  word_t      imm_b;
  word_t      imm_u;
  word_t      imm_j;
  alu_op_t    f3_op;
  logic       f3_valid;
  logic       f3_shift;
  logic       legal;
  logic       writes_rd;

  assign opcode = instr_i[6:0];
  assign funct3 = instr_i[14:12];
  assign funct7 = instr_i[31:25];

  assign dec.rs1 = instr_i[19:15];
  assign dec.rs2 = instr_i[24:20];
  assign dec.rd  = instr_i[11:7];

  // immediate formats
  assign imm_i = {{20{instr_i[31]}}, instr_i[31:20]};
  assign imm_s = {{20{instr_i[31]}}, instr_i[31:25], instr_i[11:7]};
  assign imm_b = {{19{instr_i[31]}}, instr_i[31], instr_i[7], instr_i[30:25],
                  instr_i[11:8], 1'b0};
  assign imm_u = {instr_i[31:12], 12'b0};
  assign imm_j = {{11{instr_i[31]}}, instr_i[31], instr_i[19:12], instr_i[20],
                  instr_i[30:21], 1'b0};

  // funct3 mapping shared by register and immediate forms
  always_comb begin
    case (funct3)
      3'b001:  f3_op = ALU_SLL;
      3'b010:  f3_op = ALU_SLT;
      3'b100:  f3_op = ALU_XOR;
      3'b101:  f3_op = ALU_SRL;
      3'b110:  f3_op = ALU_OR;
      3'b111:  f3_op = ALU_AND;
      default: f3_op = ALU_ADD;
    endcase
  end

  // sltu has no slot here
  assign f3_valid = (funct3 != 3'b011);
  assign f3_shift = (funct3 == 3'b001) || (funct3 == 3'b101);

  always_comb begin
    legal        = 1'b0;
    writes_rd    = 1'b0;
    dec.imm      = imm_i;
    dec.alu_op   = ALU_ADD;
    dec.negate_b = 1'b0;
    dec.a_src    = A_REG;
    dec.b_src    = B_IMM;
    dec.mem_r    = 1'b0;
    dec.mem_w    = 1'b0;
    dec.wb_src   = WB_ALU;
    dec.next_pc  = NPC_INC;

    case (opcode)
      OP_LUI: begin
        legal     = 1'b1;
        writes_rd = 1'b1;
        dec.imm   = imm_u;
        dec.a_src = A_ZERO;
      end
      OP_IMM: begin
        // no immediate shifts
        legal      = f3_valid && !f3_shift;
        writes_rd  = 1'b1;
        dec.alu_op = f3_op;
      end
      OP_REG: begin
        legal = f3_valid && ((funct7 == 7'b0000000) ||
                             (funct7 == 7'b0100000 && funct3 == 3'b000));
        writes_rd    = 1'b1;
        dec.alu_op   = f3_op;
        dec.b_src    = B_REG;
        dec.negate_b = funct7[5];
      end
      OP_LOAD: begin
        legal      = (funct3 == 3'b010);
        writes_rd  = 1'b1;
        dec.mem_r  = 1'b1;
        dec.wb_src = WB_MEM;
      end
      OP_STORE: begin
        legal     = (funct3 == 3'b010);
        dec.imm   = imm_s;
        dec.mem_w = 1'b1;
      end
      OP_BRANCH: begin
        // compare as rs1 - rs2, zero test happens on the result
        legal        = (funct3 == 3'b000) || (funct3 == 3'b001);
        dec.imm      = imm_b;
        dec.b_src    = B_REG;
        dec.negate_b = 1'b1;
        dec.next_pc  = funct3[0] ? NPC_BR_NE : NPC_BR_EQ;
      end
      OP_JAL: begin
        legal       = 1'b1;
        writes_rd   = 1'b1;
        dec.imm     = imm_j;
        dec.a_src   = A_PC;
        dec.wb_src  = WB_PC4;
        dec.next_pc = NPC_JUMP;
      end
      default: legal = 1'b0;
    endcase

    // unsupported encodings fall back to a plain pc + 4
    if (!legal) begin
      dec.mem_r   = 1'b0;
      dec.mem_w   = 1'b0;
      dec.next_pc = NPC_INC;
    end
  end

  assign dec.nop   = !legal;
  assign dec.reg_w = legal && writes_rd && (dec.rd != 5'd0);

endmodule

//--- rtl/regfile.sv
`timescale 1ns/1ps

module regfile import core_pkg::*; (
  input  logic     clk_i,
  input  reg_idx_t rs1_i,
  input  reg_idx_t rs2_i,
  output word_t    rd1_o,
  output word_t    rd2_o,
  input  logic     we_i,
  input  reg_idx_t ws_i,
  input  word_t    wd_i
);

  word_t regs [32];

  always_ff @(posedge clk_i) begin
    if (we_i && ws_i != 5'd0) begin
      regs[ws_i] <= wd_i;
    end
  end

  // x0 reads as zero
  assign rd1_o = (rs1_i == 5'd0) ? '0 : regs[rs1_i];
  assign rd2_o = (rs2_i == 5'd0) ? '0 : regs[rs2_i];

endmodule

//--- rtl/alu.sv
`timescale 1ns/1ps

module alu import core_pkg::*; (
  input  alu_op_t op_i,
  input  word_t   a_i,
  input  word_t   b_i,
  output word_t   out_o
);

  logic [4:0] shamt;

  assign shamt = b_i[4:0];

  always_comb begin
    case (op_i)
      ALU_ADD: out_o = a_i + b_i;
      ALU_AND: out_o = a_i & b_i;
      ALU_OR:  out_o = a_i | b_i;
      ALU_XOR: out_o = a_i ^ b_i;
      // signed compare
      ALU_SLT: out_o = {31'b0, $signed(a_i) < $signed(b_i)};
      ALU_SLL: out_o = a_i << shamt;
      ALU_SRL: out_o = a_i >> shamt;
      default: out_o = '0;
    endcase
  end

endmodule

//--- rtl/stage_ctrl.sv
`timescale 1ns/1ps

module stage_ctrl import core_pkg::*; (
  input  logic        clk_i,
  input  logic        rst_i,
  decode_if.control   dec,
  input  logic        instr_res_valid_i,
  input  logic        mem_read_res_valid_i,
  input  logic        mem_write_res_valid_i,
  output ctrl_state_t state_o,
  output logic        instr_req_valid_o,
  output logic        mem_read_req_valid_o,
  output logic        mem_write_req_valid_o,
  output logic        reg_we_o,
  output logic        pc_load_o
);

  ctrl_state_t state_q;
  ctrl_state_t state_d;
  logic        run_q;

  // run_q keeps fetch requests off while reset is held
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      state_q <= FETCH;
      run_q   <= 1'b0;
    end else begin
      state_q <= state_d;
      run_q   <= 1'b1;
    end
  end

  always_comb begin
    state_d = state_q;
    case (state_q)
      FETCH: begin
        if (instr_res_valid_i) begin
          state_d = DECODE;
        end
      end
      DECODE: state_d = dec.nop ? FETCH : EX;
      EX:     state_d = (dec.mem_r || dec.mem_w) ? MEM : WB;
      MEM: begin
        // wait here until the matching response shows up
        if (dec.mem_r && mem_read_res_valid_i) begin
          state_d = WB;
        end else if (dec.mem_w && mem_write_res_valid_i) begin
          state_d = FETCH;
        end
      end
      WB:      state_d = FETCH;
      default: state_d = FETCH;
    endcase
  end

  assign state_o               = state_q;
  assign instr_req_valid_o     = run_q && (state_q == FETCH);
  assign mem_read_req_valid_o  = (state_q == MEM) && dec.mem_r;
  assign mem_write_req_valid_o = (state_q == MEM) && dec.mem_w;
  assign reg_we_o              = (state_q == WB) && dec.reg_w;

  // instruction retires on the way back to fetch
  assign pc_load_o = (state_q != FETCH) && (state_d == FETCH);

endmodule

//--- rtl/datapath.sv
`timescale 1ns/1ps

module datapath import core_pkg::*; #(
  parameter word_t boot_addr = '0
) (
  input  logic        clk_i,
  input  logic        rst_i,
  decode_if.sink      dec,
  input  ctrl_state_t state_i,
  input  logic        reg_we_i,
  input  logic        pc_load_i,
  input  logic        instr_res_valid_i,
  input  word_t       instr_res_data_i,
  input  logic        mem_read_res_valid_i,
  input  word_t       mem_read_res_data_i,
  output word_t       instr_o,
  output word_t       instr_req_addr_o,
  output word_t       mem_addr_o,
  output word_t       mem_write_data_o
);

  word_t pc_q;
  word_t pc_d;
  word_t pc_plus4;
  word_t instr_q;
  word_t imm_q;
  word_t alu_q;
  word_t store_q;
  word_t rdata_q;
  word_t rd1;
  word_t rd2;
  word_t alu_a;
  word_t alu_b;
  word_t alu_out;
  word_t wdata;
  logic  alu_zero;

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      pc_q <= boot_addr;
    end else if (pc_load_i) begin
      pc_q <= pc_d;
    end
  end

  // stage registers, each loaded as its own state ends
  always_ff @(posedge clk_i) begin
    if (state_i == FETCH && instr_res_valid_i) begin
      instr_q <= instr_res_data_i;
    end
    if (state_i == DECODE) begin
      imm_q <= dec.imm;
    end
    if (state_i == EX) begin
      alu_q   <= alu_out;
      store_q <= rd2;
    end
    if (state_i == MEM && mem_read_res_valid_i) begin
      rdata_q <= mem_read_res_data_i;
    end
  end

  regfile u_regfile (
    .clk_i (clk_i),
    .rs1_i (dec.rs1),
    .rs2_i (dec.rs2),
    .rd1_o (rd1),
    .rd2_o (rd2),
    .we_i  (reg_we_i),
    .ws_i  (dec.rd),
    .wd_i  (wdata)
  );

  always_comb begin
    case (dec.a_src)
      A_PC:    alu_a = pc_q;
      A_ZERO:  alu_a = '0;
      default: alu_a = rd1;
    endcase
  end

  // negation only applies to the register operand
  assign alu_b = (dec.b_src == B_IMM) ? imm_q : (dec.negate_b ? -rd2 : rd2);

  alu u_alu (
    .op_i  (dec.alu_op),
    .a_i   (alu_a),
    .b_i   (alu_b),
    .out_o (alu_out)
  );

  assign pc_plus4 = pc_q + 32'd4;

  always_comb begin
    case (dec.wb_src)
      WB_MEM:  wdata = rdata_q;
      WB_PC4:  wdata = pc_plus4;
      default: wdata = alu_q;
    endcase
  end

  // branches compare through rs1 - rs2 held in alu_q
  assign alu_zero = (alu_q == '0);

  always_comb begin
    case (dec.next_pc)
      NPC_JUMP:  pc_d = {alu_q[31:1], 1'b0};
      NPC_BR_EQ: pc_d = alu_zero ? pc_q + imm_q : pc_plus4;
      NPC_BR_NE: pc_d = alu_zero ? pc_plus4 : pc_q + imm_q;
      default:   pc_d = pc_plus4;
    endcase
  end

  assign instr_o          = instr_q;
  assign instr_req_addr_o = pc_q;
  assign mem_addr_o       = alu_q;
  assign mem_write_data_o = store_q;

endmodule

//--- rtl/lemon_core.sv
`timescale 1ns/1ps

module lemon_core import core_pkg::*; #(
  parameter word_t boot_addr = '0
) (
  input  logic  clk_i,
  input  logic  rst_i,

  output word_t instr_req_addr_o,
  output logic  instr_req_valid_o,
  input  word_t instr_res_data_i,
  input  logic  instr_res_valid_i,

  output word_t mem_read_req_addr_o,
  output logic  mem_read_req_valid_o,
  input  word_t mem_read_res_data_i,
  input  logic  mem_read_res_valid_i,

  output word_t mem_write_req_addr_o,
  output word_t mem_write_req_data_o,
  output logic  mem_write_req_valid_o,
  input  logic  mem_write_res_valid_i
);

  ctrl_state_t state;
  word_t       instr;
  word_t       mem_addr;
  logic        reg_we;
  logic        pc_load;

  decode_if dec_bus ();

  decoder u_decoder (
    .instr_i (instr),
    .dec     (dec_bus.source)
  );

  stage_ctrl u_stage_ctrl (
    .clk_i                 (clk_i),
    .rst_i                 (rst_i),
    .dec                   (dec_bus.control),
    .instr_res_valid_i     (instr_res_valid_i),
    .mem_read_res_valid_i  (mem_read_res_valid_i),
    .mem_write_res_valid_i (mem_write_res_valid_i),
    .state_o               (state),
    .instr_req_valid_o     (instr_req_valid_o),
    .mem_read_req_valid_o  (mem_read_req_valid_o),
    .mem_write_req_valid_o (mem_write_req_valid_o),
    .reg_we_o              (reg_we),
    .pc_load_o             (pc_load)
  );

  datapath #(
    .boot_addr (boot_addr)
  ) u_datapath (
    .clk_i                (clk_i),
    .rst_i                (rst_i),
    .dec                  (dec_bus.sink),
    .state_i              (state),
    .reg_we_i             (reg_we),
    .pc_load_i            (pc_load),
    .instr_res_valid_i    (instr_res_valid_i),
    .instr_res_data_i     (instr_res_data_i),
    .mem_read_res_valid_i (mem_read_res_valid_i),
    .mem_read_res_data_i  (mem_read_res_data_i),
    .instr_o              (instr),
    .instr_req_addr_o     (instr_req_addr_o),
    .mem_addr_o           (mem_addr),
    .mem_write_data_o     (mem_write_req_data_o)
  );

  // one address serves both data channels
  assign mem_read_req_addr_o  = mem_addr;
  assign mem_write_req_addr_o = mem_addr;

endmodule

//--- tests/core_checker.sv
`timescale 1ns/1ps

module core_checker import core_pkg::*; (
  input logic  clk_i,
  input logic  rst_i,
  input word_t instr_addr_i,
  input logic  instr_valid_i,
  input logic  instr_res_i,
  input word_t rd_addr_i,
  input logic  rd_valid_i,
  input logic  rd_res_i,
  input word_t wr_addr_i,
  input word_t wr_data_i,
  input logic  wr_valid_i,
  input logic  wr_res_i
);

  // unanswered requests hold still
  a_instr_hold: assert property (@(posedge clk_i) disable iff (rst_i)
    instr_valid_i && !instr_res_i |=> instr_valid_i && $stable(instr_addr_i))
    else $error("instruction request changed before its response");

  a_read_hold: assert property (@(posedge clk_i) disable iff (rst_i)
    rd_valid_i && !rd_res_i |=> rd_valid_i && $stable(rd_addr_i))
    else $error("read request changed before its response");

  a_write_hold: assert property (@(posedge clk_i) disable iff (rst_i)
    wr_valid_i && !wr_res_i |=> wr_valid_i && $stable(wr_addr_i) && $stable(wr_data_i))
    else $error("write request changed before its response");

  a_rd_wr_excl: assert property (@(posedge clk_i) disable iff (rst_i)
    !(rd_valid_i && wr_valid_i))
    else $error("read and write requests active together");

  a_instr_data_excl: assert property (@(posedge clk_i) disable iff (rst_i)
    !(instr_valid_i && (rd_valid_i || wr_valid_i)))
    else $error("instruction and data requests active together");

  a_instr_align: assert property (@(posedge clk_i) disable iff (rst_i)
    instr_valid_i |-> instr_addr_i[1:0] == 2'b00)
    else $error("instruction address not word aligned");

endmodule

bind lemon_core core_checker u_core_checker (
  .clk_i         (clk_i),
  .rst_i         (rst_i),
  .instr_addr_i  (instr_req_addr_o),
  .instr_valid_i (instr_req_valid_o),
  .instr_res_i   (instr_res_valid_i),
  .rd_addr_i     (mem_read_req_addr_o),
  .rd_valid_i    (mem_read_req_valid_o),
  .rd_res_i      (mem_read_res_valid_i),
  .wr_addr_i     (mem_write_req_addr_o),
  .wr_data_i     (mem_write_req_data_o),
  .wr_valid_i    (mem_write_req_valid_o),
  .wr_res_i      (mem_write_res_valid_i)
);

//--- tests/core_monitor.sv
`timescale 1ns/1ps

module core_monitor import core_pkg::*; #(
  parameter word_t boot_addr = '0
) (
  input  logic  clk_i,
  input  logic  rst_i,
  input  word_t instr_req_addr_i,
  input  logic  instr_req_valid_i,
  input  word_t instr_res_data_i,
  input  logic  instr_res_valid_i,
  input  word_t rd_addr_i,
  input  logic  rd_valid_i,
  input  logic  rd_res_valid_i,
  input  word_t wr_addr_i,
  input  word_t wr_data_i,
  input  logic  wr_valid_i,
  input  logic  wr_res_valid_i,
  output logic  done_o,
  output int    fetch_errors_o,
  output int    load_errors_o,
  output int    store_errors_o,
  output int    mem_errors_o
);

  word_t x [32];
  word_t mem [16];
  logic  written [16];
  word_t pc;
  logic  pend;
  logic  load_pend;
  word_t exp_addr;
  word_t exp_data;
  word_t exp_load_addr;

  // reference ISA model stepping one instruction per fetch
  task automatic execute(input word_t w);
    logic [2:0] f3;
    logic [6:0] f7;
    reg_idx_t   rd;
    word_t      a;
    word_t      b;
    word_t      ii;
    word_t      is;
    word_t      ib;
    word_t      ij;
    word_t      res;
    word_t      npc;
    word_t      ea;
    logic       wr;
    f3  = w[14:12];
    f7  = w[31:25];
    rd  = w[11:7];
    a   = x[w[19:15]];
    b   = x[w[24:20]];
    ii  = {{20{w[31]}}, w[31:20]};
    is  = {{20{w[31]}}, w[31:25], w[11:7]};
    ib  = {{19{w[31]}}, w[31], w[7], w[30:25], w[11:8], 1'b0};
    ij  = {{11{w[31]}}, w[31], w[19:12], w[20], w[30:21], 1'b0};
    npc = pc + 32'd4;
    wr  = 1'b0;
    res = '0;
    case (w[6:0])
      OP_LUI: begin
        wr  = 1'b1;
        res = {w[31:12], 12'b0};
      end
      OP_IMM: begin
        wr = 1'b1;
        case (f3)
          3'b000:  res = a + ii;
          3'b010:  res = {31'b0, $signed(a) < $signed(ii)};
          3'b100:  res = a ^ ii;
          3'b110:  res = a | ii;
          3'b111:  res = a & ii;
          default: wr = 1'b0;
        endcase
      end
      OP_REG: begin
        wr = (f7 == 7'h00) || (f7 == 7'h20 && f3 == 3'b000);
        case (f3)
          3'b000:  res = f7[5] ? a - b : a + b;
          3'b001:  res = a << b[4:0];
          3'b010:  res = {31'b0, $signed(a) < $signed(b)};
          3'b100:  res = a ^ b;
          3'b101:  res = a >> b[4:0];
          3'b110:  res = a | b;
          3'b111:  res = a & b;
          default: wr = 1'b0;
        endcase
      end
      OP_LOAD: begin
        if (f3 == 3'b010) begin
          ea            = a + ii;
          wr            = 1'b1;
          res           = mem[ea[5:2]];
          load_pend     = 1'b1;
          exp_load_addr = ea;
        end
      end
      OP_STORE: begin
        if (f3 == 3'b010) begin
          ea                = a + is;
          pend              = 1'b1;
          exp_addr          = ea;
          exp_data          = b;
          mem[ea[5:2]]      = b;
          written[ea[5:2]]  = 1'b1;
        end
      end
      OP_BRANCH: begin
        if ((f3 == 3'b000 && a == b) || (f3 == 3'b001 && a != b)) begin
          npc = pc + ib;
        end
      end
      OP_JAL: begin
        wr  = 1'b1;
        res = pc + 32'd4;
        npc = pc + ij;
      end
      default: wr = 1'b0;
    endcase
    if (wr && rd != 5'd0) begin
      x[rd] = res;
    end
    pc = npc;
  endtask

  task automatic finish_run();
    for (int i = 0; i < 16; i++) begin
      if (written[i] && tb_top.dmem[i] !== mem[i]) begin
        $display("FAIL final_memory[%0d]: expected %h, actual %h", i, mem[i],
                 tb_top.dmem[i]);
        mem_errors_o++;
      end
    end
    done_o = 1'b1;
  endtask

  always @(posedge clk_i) begin
    if (rst_i) begin
      pc             = boot_addr;
      pend           = 1'b0;
      load_pend      = 1'b0;
      done_o         = 1'b0;
      fetch_errors_o = 0;
      load_errors_o  = 0;
      store_errors_o = 0;
      mem_errors_o   = 0;
      for (int i = 0; i < 32; i++) begin
        x[i] = '0;
      end
      for (int i = 0; i < 16; i++) begin
        mem[i]     = 32'h5a5a0000 ^ (word_t'(256 + 4 * i) * 32'h00010003);
        written[i] = 1'b0;
      end
    end else if (!done_o) begin
      if (rd_valid_i && rd_res_valid_i) begin
        if (!load_pend) begin
          $display("ERROR: read request seen while no load was executing");
          load_errors_o++;
        end else begin
          if (rd_addr_i !== exp_load_addr) begin
            $display("FAIL load_addr: expected %h, actual %h", exp_load_addr, rd_addr_i);
            load_errors_o++;
          end
          load_pend = 1'b0;
        end
      end
      if (wr_valid_i && wr_res_valid_i) begin
        if (!pend) begin
          $display("ERROR: write request seen while no store was executing");
          store_errors_o++;
        end else begin
          if (wr_addr_i !== exp_addr) begin
            $display("FAIL store_addr: expected %h, actual %h", exp_addr, wr_addr_i);
            store_errors_o++;
          end
          if (wr_data_i !== exp_data) begin
            $display("FAIL store_data: expected %h, actual %h", exp_data, wr_data_i);
            store_errors_o++;
          end
          pend = 1'b0;
        end
      end
      if (instr_req_valid_i && instr_res_valid_i) begin
        if (pend) begin
          $display("ERROR: next fetch started before the store to %h was written", exp_addr);
          store_errors_o++;
          pend = 1'b0;
        end
        if (load_pend) begin
          $display("ERROR: next fetch started before the load from %h was read",
                   exp_load_addr);
          load_errors_o++;
          load_pend = 1'b0;
        end
        if (instr_req_addr_i !== pc) begin
          $display("FAIL fetch_addr: expected %h, actual %h", pc, instr_req_addr_i);
          fetch_errors_o++;
        end
        // a jal to itself marks the end of the program
        if (instr_res_data_i == 32'h0000006f) begin
          finish_run();
        end else begin
          execute(instr_res_data_i);
        end
      end
    end
  end

endmodule

//--- tests/tb_top.sv
`timescale 1ns/1ps

module tb_top import core_pkg::*; ();

  localparam word_t BOOT = 32'h0;
  // 72 instructions at 11 cycles worst case each plus margin
  localparam int TIMEOUT = (64 + 8) * 11 + 100;

  logic        clk_i;
  logic        rst_i;
  word_t       instr_req_addr;
  logic        instr_req_valid;
  word_t       instr_res_data;
  logic        instr_res_valid;
  word_t       rd_addr;
  logic        rd_valid;
  word_t       rd_data;
  logic        rd_res_valid;
  word_t       wr_addr;
  word_t       wr_data;
  logic        wr_valid;
  logic        wr_res_valid;
  logic        i_busy;
  logic        r_busy;
  logic        w_busy;
  logic [1:0]  i_cnt;
  logic [1:0]  r_cnt;
  logic [1:0]  w_cnt;
  logic        done;
  int          fetch_errors;
  int          load_errors;
  int          store_errors;
  int          mem_errors;
  int          cycles;
  logic [31:0] lfsr = 32'hd91af2d3;
  word_t       imem [128];
  word_t       dmem [16];

  // fibonacci lfsr with taps 32 22 2 1 stepped once per bit
  function automatic logic [31:0] take_bits(input int n);
    logic [31:0] r;
    logic        fb;
    r = '0;
    for (int k = 0; k < n; k++) begin
      fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
      lfsr = {lfsr[30:0], fb};
      r    = {r[30:0], fb};
    end
    return r;
  endfunction

  // x1 to x7
  function automatic reg_idx_t pick_reg();
    logic [31:0] r;
    r = take_bits(3);
    return (r == 0) ? 5'd7 : r[4:0];
  endfunction

  function automatic word_t enc_r(logic [6:0] f7, reg_idx_t rs2, reg_idx_t rs1,
                                  logic [2:0] f3, reg_idx_t rd);
    return {f7, rs2, rs1, f3, rd, OP_REG};
  endfunction

  function automatic word_t enc_i(logic [11:0] imm, reg_idx_t rs1, logic [2:0] f3,
                                  reg_idx_t rd, opcode_t op);
    return {imm, rs1, f3, rd, op};
  endfunction

  function automatic word_t enc_s(logic [11:0] imm, reg_idx_t rs2, reg_idx_t rs1);
    return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], OP_STORE};
  endfunction

  function automatic word_t enc_b(logic [12:0] off, reg_idx_t rs2, reg_idx_t rs1,
                                  logic [2:0] f3);
    return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], OP_BRANCH};
  endfunction

  function automatic word_t enc_j(logic [20:0] off, reg_idx_t rd);
    return {off[20], off[10:1], off[11], off[19:12], rd, OP_JAL};
  endfunction

  task automatic build_program();
    logic [31:0] kind;
    logic [31:0] hi;
    logic [31:0] imm;
    logic [31:0] moff;
    logic [31:0] sel;
    int          off;
    reg_idx_t    rd;
    reg_idx_t    rs1;
    reg_idx_t    rs2;
    word_t       w;
    for (int i = 0; i < 128; i++) begin
      imem[i] = 32'h0badf00d ^ word_t'(4 * i);
    end
    // registers start from known values
    for (int r = 1; r < 8; r++) begin
      imm = take_bits(12);
      imem[r - 1] = enc_i(imm[11:0], 5'd0, 3'b000, 5'(r), OP_IMM);
    end
    for (int i = 7; i < 64; i++) begin
      kind = take_bits(4);
      rd   = pick_reg();
      rs1  = pick_reg();
      rs2  = pick_reg();
      imm  = take_bits(12);
      hi   = take_bits(20);
      moff = 256 + 4 * take_bits(4);
      sel  = take_bits(2);
      off  = 4 * (1 + int'(take_bits(3)));
      // forward only and never past the body
      if (i + off / 4 > 64) begin
        off = (64 - i) * 4;
      end
      case (kind)
        0:  w = {hi[19:0], rd, OP_LUI};
        1:  w = enc_i(imm[11:0], rs1, 3'b000, rd, OP_IMM);
        2:  w = enc_i(imm[11:0], rs1, 3'b111, rd, OP_IMM);
        3:  w = enc_i(imm[11:0], rs1, 3'b110, rd, OP_IMM);
        4:  w = enc_i(imm[11:0], rs1, 3'b100, rd, OP_IMM);
        5:  w = enc_i(imm[11:0], rs1, 3'b010, rd, OP_IMM);
        6:  w = enc_r(7'h00, rs2, rs1, 3'b000, rd);
        7:  w = enc_r(7'h20, rs2, rs1, 3'b000, rd);
        8:  w = enc_r(7'h00, rs2, rs1, 3'b111, rd);
        9:  w = enc_r(7'h00, rs2, rs1, 3'b110, rd);
        10: w = enc_r(7'h00, rs2, rs1, 3'b100, rd);
        11: w = enc_r(7'h00, rs2, rs1, 3'b010, rd);
        12: w = enc_r(7'h00, rs2, rs1, 3'b001, rd);
        13: w = enc_r(7'h00, rs2, rs1, 3'b101, rd);
        14: w = sel[0] ? enc_i(moff[11:0], 5'd0, 3'b010, rd, OP_LOAD)
                      : enc_s(moff[11:0], rs2, 5'd0);
        default: begin
          case (sel)
            0:       w = enc_b(13'(off), rs2, rs1, 3'b000);
            1:       w = enc_b(13'(off), rs2, rs1, 3'b001);
            2:       w = enc_j(21'(off), rd);
            default: w = 32'h0000_0000;
          endcase
        end
      endcase
      imem[i] = w;
    end
    // tail stores x1..x7 and then jumps to itself
    for (int r = 1; r < 8; r++) begin
      imem[63 + r] = enc_s(12'(256 + 4 * (r - 1)), 5'(r), 5'd0);
    end
    imem[71] = enc_j(21'd0, 5'd0);
  endtask

  task automatic respond(input logic req, inout logic busy, inout logic [1:0] cnt,
                         output logic res);
    res = 1'b0;
    if (req) begin
      if (!busy) begin
        busy = 1'b1;
        cnt  = 2'(take_bits(2));
      end
      if (cnt == 2'd0) begin
        res  = 1'b1;
        busy = 1'b0;
      end else begin
        cnt = cnt - 2'd1;
      end
    end
  endtask

  initial begin
    clk_i = 1'b0;
    forever #5 clk_i = ~clk_i;
  end

  initial begin
    rst_i           = 1'b1;
    instr_res_data  = '0;
    instr_res_valid = 1'b0;
    rd_data         = '0;
    rd_res_valid    = 1'b0;
    wr_res_valid    = 1'b0;
    build_program();
    for (int i = 0; i < 16; i++) begin
      dmem[i] = 32'h5a5a0000 ^ (word_t'(256 + 4 * i) * 32'h00010003);
    end
    repeat (10) @(posedge clk_i);
    @(negedge clk_i);
    rst_i  = 1'b0;
    cycles = 0;
    while (!done && cycles < TIMEOUT) begin
      @(negedge clk_i);
      cycles++;
    end
    if (!done) begin
      $display("ERROR: core stopped fetching, no self loop after %0d cycles", cycles);
    end
    $display("errors: fetch=%0d load=%0d store=%0d memory=%0d timeout=%0d",
             fetch_errors, load_errors, store_errors, mem_errors, !done);
    if (done && fetch_errors + load_errors + store_errors + mem_errors == 0) begin
      $display("Result: PASSED");
    end else begin
      $display("Result: FAILED");
    end
    $finish;
  end

  // responders act on the falling edge
  always @(negedge clk_i) begin
    if (rst_i) begin
      i_busy          = 1'b0;
      r_busy          = 1'b0;
      w_busy          = 1'b0;
      instr_res_valid = 1'b0;
      rd_res_valid    = 1'b0;
      wr_res_valid    = 1'b0;
    end else begin
      respond(instr_req_valid, i_busy, i_cnt, instr_res_valid);
      if (instr_res_valid) begin
        instr_res_data = imem[instr_req_addr[8:2]];
      end
      respond(rd_valid, r_busy, r_cnt, rd_res_valid);
      if (rd_res_valid) begin
        rd_data = dmem[rd_addr[5:2]];
      end
      respond(wr_valid, w_busy, w_cnt, wr_res_valid);
      if (wr_res_valid) begin
        dmem[wr_addr[5:2]] = wr_data;
      end
    end
  end

  lemon_core #(
    .boot_addr (BOOT)
  ) dut (
    .clk_i                 (clk_i),
    .rst_i                 (rst_i),
    .instr_req_addr_o      (instr_req_addr),
    .instr_req_valid_o     (instr_req_valid),
    .instr_res_data_i      (instr_res_data),
    .instr_res_valid_i     (instr_res_valid),
    .mem_read_req_addr_o   (rd_addr),
    .mem_read_req_valid_o  (rd_valid),
    .mem_read_res_data_i   (rd_data),
    .mem_read_res_valid_i  (rd_res_valid),
    .mem_write_req_addr_o  (wr_addr),
    .mem_write_req_data_o  (wr_data),
    .mem_write_req_valid_o (wr_valid),
    .mem_write_res_valid_i (wr_res_valid)
  );

  core_monitor #(
    .boot_addr (BOOT)
  ) u_monitor (
    .clk_i             (clk_i),
    .rst_i             (rst_i),
    .instr_req_addr_i  (instr_req_addr),
    .instr_req_valid_i (instr_req_valid),
    .instr_res_data_i  (instr_res_data),
    .instr_res_valid_i (instr_res_valid),
    .rd_addr_i         (rd_addr),
    .rd_valid_i        (rd_valid),
    .rd_res_valid_i    (rd_res_valid),
    .wr_addr_i         (wr_addr),
    .wr_data_i         (wr_data),
    .wr_valid_i        (wr_valid),
    .wr_res_valid_i    (wr_res_valid),
    .done_o            (done),
    .fetch_errors_o    (fetch_errors),
    .load_errors_o     (load_errors),
    .store_errors_o    (store_errors),
    .mem_errors_o      (mem_errors)
  );

endmodule

//--- flist.f
rtl/core_pkg.sv
rtl/decode_if.sv
rtl/decoder.sv
rtl/regfile.sv
rtl/alu.sv
rtl/stage_ctrl.sv
rtl/datapath.sv
rtl/lemon_core.sv
tests/core_checker.sv
tests/core_monitor.sv
tests/tb_top.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= tb_top
FLIST     ?= flist.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal -j 0

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator and run the simulation"
	@echo "  clean  remove build output and log"
	@echo "variables: VERILATOR TOP FLIST BUILD_DIR LOG VFLAGS"

$(BUILD_DIR)/V$(TOP): $(FLIST) $(shell cat $(FLIST))
	$(VERILATOR) $(VFLAGS) -f $(FLIST) --top-module $(TOP) -Mdir $(BUILD_DIR)

test: $(BUILD_DIR)/V$(TOP)
	@$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1; echo "exit status $$?" >> $(LOG)
	@cat $(LOG)
	@if grep -q "Result: FAILED" $(LOG) || ! grep -q "exit status 0" $(LOG); then \
		echo "simulation failed, see $(LOG)"; exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
